// File: rtl/tl_pkg.sv
// ==========================================================
// TileLink-UL field widths, opcodes and channel field types
// Shared by the bus interface, the switch and every slave
// ==========================================================
`default_nettype none

package tl_pkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int XLEN       = 32;        // Address and data width
    localparam int SID_WIDTH  = 8;         // Source ID width
    localparam int MASK_WIDTH = XLEN / 8;  // One bit per byte lane

    // ==========================================================
    // Opcodes
    // ==========================================================
    typedef enum logic [2:0] {
        PUT_FULL_DATA    = 3'd0,
        PUT_PARTIAL_DATA = 3'd1,
        GET              = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        ACCESS_ACK      = 3'd0,  // Response to a Put
        ACCESS_ACK_DATA = 3'd1   // Response to a Get
    } tl_d_opcode_e;

    // ==========================================================
    // Channel fields
    // ==========================================================
    typedef logic [2:0]            tl_size_t;    // log2 of bytes
    typedef logic [SID_WIDTH-1:0]  tl_source_t;
    typedef logic [XLEN-1:0]       tl_addr_t;
    typedef logic [XLEN-1:0]       tl_data_t;
    typedef logic [MASK_WIDTH-1:0] tl_mask_t;

endpackage

`default_nettype wire

// File: rtl/soc_map_pkg.sv
// ==========================================================
// SoC address map: slave regions, memory depth, LED count
// Used by the switch decoder and by the slaves themselves
// ==========================================================
`default_nettype none

package soc_map_pkg;

    // Data memory region
    localparam tl_pkg::tl_addr_t MEM_BASE = 32'h0000_0000;
    localparam tl_pkg::tl_addr_t MEM_MASK = 32'h0000_FFFF;

    // LED output region
    localparam tl_pkg::tl_addr_t OUT_BASE = 32'h0002_0000;
    localparam tl_pkg::tl_addr_t OUT_MASK = 32'h0000_000F;

    // Word count of the data memory
    // Indexed by address bits 11:2, aliases every 4 KB
    localparam int MEM_WORDS = 1024;

    localparam int LED_COUNT = 6;  // Board LEDs

endpackage

`default_nettype wire

// File: rtl/tl_ul_if.sv
// ==========================================================
// TileLink-UL A and D channel bundle between switch and slave
// Switch side takes the master modport, slave side the slave
// ==========================================================
`default_nettype none

interface tl_ul_if;
    import tl_pkg::*;

    // A channel, master to slave
    logic         a_valid;
    logic         a_ready;
    tl_a_opcode_e a_opcode;
    tl_size_t     a_param;
    tl_size_t     a_size;
    tl_source_t   a_source;
    tl_addr_t     a_address;
    tl_mask_t     a_mask;
    tl_data_t     a_data;

    // D channel, slave to master
    logic         d_valid;
    logic         d_ready;
    tl_d_opcode_e d_opcode;
    tl_size_t     d_param;  // Always zero
    tl_size_t     d_size;
    tl_source_t   d_source;
    tl_data_t     d_data;
    logic         d_denied;
    logic         d_corrupt;  // Always zero

    modport master (
        output a_valid, a_opcode, a_param, a_size, a_source, a_address, a_mask, a_data,
        input  a_ready,
        input  d_valid, d_opcode, d_param, d_size, d_source, d_data, d_denied, d_corrupt,
        output d_ready
    );

    modport slave (
        input  a_valid, a_opcode, a_param, a_size, a_source, a_address, a_mask, a_data,
        output a_ready,
        output d_valid, d_opcode, d_param, d_size, d_source, d_data, d_denied, d_corrupt,
        input  d_ready
    );

endinterface

`default_nettype wire

// File: rtl/tl_switch.sv
// ==========================================================
// Address decoder and router for one master and two slaves
// Single outstanding request, answers unmapped accesses itself
// ==========================================================
`default_nettype none

module tl_switch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a_valid,
    output logic                  a_ready,
    input  tl_pkg::tl_a_opcode_e  a_opcode,
    input  tl_pkg::tl_size_t      a_param,
    input  tl_pkg::tl_size_t      a_size,
    input  tl_pkg::tl_source_t    a_source,
    input  tl_pkg::tl_addr_t      a_address,
    input  tl_pkg::tl_mask_t      a_mask,
    input  tl_pkg::tl_data_t      a_data,
    output logic                  d_valid,
    input  logic                  d_ready,
    output tl_pkg::tl_d_opcode_e  d_opcode,
    output tl_pkg::tl_size_t      d_param,
    output tl_pkg::tl_size_t      d_size,
    output tl_pkg::tl_source_t    d_source,
    output tl_pkg::tl_data_t      d_data,
    output logic                  d_denied,
    output logic                  d_corrupt,
    tl_ul_if.master               mem,
    tl_ul_if.master               out
);
    import tl_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {TGT_IDLE, TGT_MEM, TGT_OUT, TGT_DENY} target_e;

    target_e      tgt_q;      // Owner of the outstanding request
    logic         hit_mem;
    logic         hit_out;
    logic         idle;
    logic         sel_ready;
    logic         a_fire;
    logic         d_fire;
    tl_d_opcode_e den_opcode;
    tl_size_t     den_size;
    tl_source_t   den_source;

    // ==========================================================
    // Decode and A channel routing
    // ==========================================================
    assign hit_mem = (a_address & ~MEM_MASK) == MEM_BASE;
    assign hit_out = (a_address & ~OUT_MASK) == OUT_BASE;
    assign idle    = (tgt_q == TGT_IDLE);

    always_comb begin
        if (hit_mem)      sel_ready = mem.a_ready;
        else if (hit_out) sel_ready = out.a_ready;
        else              sel_ready = 1'b1;  // Denied responder always free
    end

    assign a_ready = idle && sel_ready;
    assign a_fire  = a_valid && a_ready;
    assign d_fire  = d_valid && d_ready;

    assign mem.a_valid   = a_valid && idle && hit_mem;
    assign mem.a_opcode  = a_opcode;
    assign mem.a_param   = a_param;
    assign mem.a_size    = a_size;
    assign mem.a_source  = a_source;
    assign mem.a_address = a_address;
    assign mem.a_mask    = a_mask;
    assign mem.a_data    = a_data;
    assign mem.d_ready   = d_ready && (tgt_q == TGT_MEM);

    assign out.a_valid   = a_valid && idle && hit_out;
    assign out.a_opcode  = a_opcode;
    assign out.a_param   = a_param;
    assign out.a_size    = a_size;
    assign out.a_source  = a_source;
    assign out.a_address = a_address;
    assign out.a_mask    = a_mask;
    assign out.a_data    = a_data;
    assign out.d_ready   = d_ready && (tgt_q == TGT_OUT);

    // Held from A acceptance until the D beat completes
    always_ff @(posedge clk) begin
        if (rst) begin
            tgt_q <= TGT_IDLE;
        end else if (a_fire) begin
            tgt_q <= hit_mem ? TGT_MEM : (hit_out ? TGT_OUT : TGT_DENY);
        end else if (d_fire) begin
            tgt_q <= TGT_IDLE;
        end
    end

    // Echo fields for the denied response
    always_ff @(posedge clk) begin
        if (a_fire) begin
            den_opcode <= (a_opcode == GET) ? ACCESS_ACK_DATA : ACCESS_ACK;
            den_size   <= a_size;
            den_source <= a_source;
        end
    end

    // ==========================================================
    // D channel return mux
    // ==========================================================
    always_comb begin
        d_valid   = 1'b0;
        d_opcode  = den_opcode;
        d_param   = '0;
        d_size    = den_size;
        d_source  = den_source;
        d_data    = '0;
        d_denied  = 1'b0;
        d_corrupt = 1'b0;
        case (tgt_q)
            TGT_MEM: begin
                d_valid   = mem.d_valid;
                d_opcode  = mem.d_opcode;
                d_param   = mem.d_param;
                d_size    = mem.d_size;
                d_source  = mem.d_source;
                d_data    = mem.d_data;
                d_denied  = mem.d_denied;
                d_corrupt = mem.d_corrupt;
            end
            TGT_OUT: begin
                d_valid   = out.d_valid;
                d_opcode  = out.d_opcode;
                d_param   = out.d_param;
                d_size    = out.d_size;
                d_source  = out.d_source;
                d_data    = out.d_data;
                d_denied  = out.d_denied;
                d_corrupt = out.d_corrupt;
            end
            TGT_DENY: begin
                d_valid  = 1'b1;  // One cycle after acceptance
                d_denied = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/tl_memory.sv
// ==========================================================
// Word-addressed data memory slave with byte-lane writes
// Answers every accepted request one cycle later
// ==========================================================
`default_nettype none

module tl_memory (
    input  logic   clk,
    input  logic   rst,
    tl_ul_if.slave bus
);
    import tl_pkg::*;
    import soc_map_pkg::*;

    tl_data_t                     mem [MEM_WORDS];
    logic [$clog2(MEM_WORDS)-1:0] word_idx;
    logic                         a_fire;
    logic                         d_fire;
    logic                         is_put;
    logic                         rsp_valid;
    tl_d_opcode_e                 rsp_opcode;
    tl_size_t                     rsp_size;
    tl_source_t                   rsp_source;
    tl_data_t                     rsp_data;
    logic                         rsp_denied;

    assign word_idx = bus.a_address[$clog2(MEM_WORDS)+1:2];  // Drop byte offset
    assign a_fire   = bus.a_valid && !rsp_valid;
    assign d_fire   = rsp_valid && bus.d_ready;
    assign is_put   = (bus.a_opcode == PUT_FULL_DATA) || (bus.a_opcode == PUT_PARTIAL_DATA);

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (a_fire) begin
            rsp_valid <= 1'b1;
        end else if (d_fire) begin
            rsp_valid <= 1'b0;
        end
    end

    // Byte lanes enabled by the mask
    always_ff @(posedge clk) begin
        if (a_fire && is_put) begin
            for (int i = 0; i < MASK_WIDTH; i++) begin
                if (bus.a_mask[i]) begin
                    mem[word_idx][i*8 +: 8] <= bus.a_data[i*8 +: 8];
                end
            end
        end
    end

    // Response payload, held until the D beat is taken
    always_ff @(posedge clk) begin
        if (a_fire) begin
            rsp_size   <= bus.a_size;
            rsp_source <= bus.a_source;
            rsp_data   <= '0;
            rsp_denied <= 1'b0;
            case (bus.a_opcode)
                PUT_FULL_DATA, PUT_PARTIAL_DATA: rsp_opcode <= ACCESS_ACK;
                GET: begin
                    rsp_opcode <= ACCESS_ACK_DATA;
                    rsp_data   <= mem[word_idx];
                end
                default: begin
                    rsp_opcode <= ACCESS_ACK;
                    rsp_denied <= 1'b1;  // Unsupported opcode
                end
            endcase
        end
    end

    assign bus.a_ready   = !rsp_valid;
    assign bus.d_valid   = rsp_valid;
    assign bus.d_opcode  = rsp_opcode;
    assign bus.d_param   = '0;
    assign bus.d_size    = rsp_size;
    assign bus.d_source  = rsp_source;
    assign bus.d_data    = rsp_data;
    assign bus.d_denied  = rsp_denied;
    assign bus.d_corrupt = 1'b0;

endmodule

`default_nettype wire

// File: rtl/tl_ul_output.sv
// ==========================================================
// LED output register slave, one register at offset 0
// led_state is active high, the top level inverts it
// ==========================================================
`default_nettype none

module tl_ul_output (
    input  logic                            clk,
    input  logic                            rst,
    tl_ul_if.slave                          bus,
    output logic [soc_map_pkg::LED_COUNT-1:0] led_state
);
    import tl_pkg::*;
    import soc_map_pkg::*;

    logic [LED_COUNT-1:0] led_q;
    logic                 reg_hit;
    logic                 a_fire;
    logic                 d_fire;
    logic                 is_put;
    logic                 rsp_valid;
    tl_d_opcode_e         rsp_opcode;
    tl_size_t             rsp_size;
    tl_source_t           rsp_source;
    tl_data_t             rsp_data;
    logic                 rsp_denied;

    // Word offset 0 inside the region, any byte lane
    assign reg_hit = (bus.a_address & OUT_MASK & ~tl_addr_t'(MASK_WIDTH - 1)) == '0;
    assign a_fire  = bus.a_valid && !rsp_valid;
    assign d_fire  = rsp_valid && bus.d_ready;
    assign is_put  = (bus.a_opcode == PUT_FULL_DATA) || (bus.a_opcode == PUT_PARTIAL_DATA);

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            led_q     <= '0;  // All LEDs dark
        end else begin
            if (a_fire) begin
                rsp_valid <= 1'b1;
            end else if (d_fire) begin
                rsp_valid <= 1'b0;
            end
            if (a_fire && is_put && reg_hit && bus.a_mask[0]) begin
                led_q <= bus.a_data[LED_COUNT-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            rsp_size   <= bus.a_size;
            rsp_source <= bus.a_source;
            rsp_opcode <= (bus.a_opcode == GET) ? ACCESS_ACK_DATA : ACCESS_ACK;
            rsp_data   <= (bus.a_opcode == GET && reg_hit) ? tl_data_t'(led_q) : '0;
            rsp_denied <= !reg_hit || !(is_put || bus.a_opcode == GET);
        end
    end

    assign bus.a_ready   = !rsp_valid;
    assign bus.d_valid   = rsp_valid;
    assign bus.d_opcode  = rsp_opcode;
    assign bus.d_param   = '0;
    assign bus.d_size    = rsp_size;
    assign bus.d_source  = rsp_source;
    assign bus.d_data    = rsp_data;
    assign bus.d_denied  = rsp_denied;
    assign bus.d_corrupt = 1'b0;

    assign led_state = led_q;

endmodule

`default_nettype wire

// File: rtl/soc_top.sv
// ==========================================================
// TileLink-UL system top: one master port, memory and LEDs
// The external master drives the A channel and takes D
// ==========================================================
`default_nettype none

module soc_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              a_valid,
    output logic                              a_ready,
    input  tl_pkg::tl_a_opcode_e              a_opcode,
    input  tl_pkg::tl_size_t                  a_param,
    input  tl_pkg::tl_size_t                  a_size,
    input  tl_pkg::tl_source_t                a_source,
    input  tl_pkg::tl_addr_t                  a_address,
    input  tl_pkg::tl_mask_t                  a_mask,
    input  tl_pkg::tl_data_t                  a_data,
    output logic                              d_valid,
    input  logic                              d_ready,
    output tl_pkg::tl_d_opcode_e              d_opcode,
    output tl_pkg::tl_size_t                  d_param,
    output tl_pkg::tl_size_t                  d_size,
    output tl_pkg::tl_source_t                d_source,
    output tl_pkg::tl_data_t                  d_data,
    output logic                              d_denied,
    output logic                              d_corrupt,
    output logic [soc_map_pkg::LED_COUNT-1:0] led
);
    import soc_map_pkg::*;

    logic [LED_COUNT-1:0] led_state;

    tl_ul_if mem_bus ();
    tl_ul_if out_bus ();

    // ==========================================================
    // Switch
    // ==========================================================
    tl_switch switch_inst (
        .clk       (clk),
        .rst       (rst),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_opcode  (a_opcode),
        .a_param   (a_param),
        .a_size    (a_size),
        .a_source  (a_source),
        .a_address (a_address),
        .a_mask    (a_mask),
        .a_data    (a_data),
        .d_valid   (d_valid),
        .d_ready   (d_ready),
        .d_opcode  (d_opcode),
        .d_param   (d_param),
        .d_size    (d_size),
        .d_source  (d_source),
        .d_data    (d_data),
        .d_denied  (d_denied),
        .d_corrupt (d_corrupt),
        .mem       (mem_bus),
        .out       (out_bus)
    );

    // ==========================================================
    // Slaves
    // ==========================================================
    tl_memory memory_inst (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus)
    );

    tl_ul_output out_inst (
        .clk       (clk),
        .rst       (rst),
        .bus       (out_bus),
        .led_state (led_state)
    );

    assign led = ~led_state;  // Pins are active low

endmodule

`default_nettype wire

// File: testbench/tb_soc.sv
// ==========================================================
// Directed testbench for the TileLink-UL system top
// Drives the master port, checks D responses and LED pins
// ==========================================================
`default_nettype none

module tb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    import tl_pkg::*;
    import soc_map_pkg::*;

    localparam int          CLK_PERIOD     = 4;
    localparam int          DRIVE_DELAY    = 1;     // Inputs change this long after posedge
    localparam int          RESET_CYCLES   = 4;
    localparam int          TIMEOUT_CYCLES = 2000;  // Many times the total test length
    localparam logic [31:0] SEED           = 32'h1d24_fa8a;
    localparam tl_addr_t    UNMAPPED_ADDR  = 32'h0004_0000;

    logic                 clk;
    logic                 rst;
    logic                 a_valid;
    logic                 a_ready;
    tl_a_opcode_e         a_opcode;
    tl_size_t             a_param;
    tl_size_t             a_size;
    tl_source_t           a_source;
    tl_addr_t             a_address;
    tl_mask_t             a_mask;
    tl_data_t             a_data;
    logic                 d_valid;
    logic                 d_ready;
    tl_d_opcode_e         d_opcode;
    tl_size_t             d_param;
    tl_size_t             d_size;
    tl_source_t           d_source;
    tl_data_t             d_data;
    logic                 d_denied;
    logic                 d_corrupt;
    logic [LED_COUNT-1:0] led;

    // Last D beat seen by the master
    tl_d_opcode_e got_opcode;
    tl_size_t     got_param;
    tl_size_t     got_size;
    tl_source_t   got_source;
    tl_data_t     got_data;
    logic         got_denied;
    logic         got_corrupt;

    int           cycle_count = 0;
    tl_data_t     mem_model [int];  // Expected memory contents by word index

    soc_top u_soc_top (
        .clk       (clk),
        .rst       (rst),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_opcode  (a_opcode),
        .a_param   (a_param),
        .a_size    (a_size),
        .a_source  (a_source),
        .a_address (a_address),
        .a_mask    (a_mask),
        .a_data    (a_data),
        .d_valid   (d_valid),
        .d_ready   (d_ready),
        .d_opcode  (d_opcode),
        .d_param   (d_param),
        .d_size    (d_size),
        .d_source  (d_source),
        .d_data    (d_data),
        .d_denied  (d_denied),
        .d_corrupt (d_corrupt),
        .led       (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // ==========================================================
    // Checking helpers
    // ==========================================================
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("FAIL %s: %s expected %h, actual %h",
                                     test, field, expected, actual));
        end
    endtask

    function automatic int word_index(input tl_addr_t addr);
        return int'(addr[11:2]);  // Memory aliases every 4 KB
    endfunction

    function automatic tl_data_t merge_bytes(input tl_data_t old_word, input tl_data_t new_word,
                                             input tl_mask_t mask);
        tl_data_t result;
        result = old_word;
        for (int i = 0; i < MASK_WIDTH; i++) begin
            if (mask[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

    // Data is compared for AccessAckData and for denied beats
    task automatic check_response(input string test, input tl_d_opcode_e exp_opcode,
                                  input tl_source_t exp_source, input tl_size_t exp_size,
                                  input logic exp_denied, input tl_data_t exp_data);
        check_value(test, "d_opcode", 32'(exp_opcode), 32'(got_opcode));
        check_value(test, "d_source", 32'(exp_source), 32'(got_source));
        check_value(test, "d_size", 32'(exp_size), 32'(got_size));
        check_value(test, "d_denied", 32'(exp_denied), 32'(got_denied));
        check_value(test, "d_param", 32'd0, 32'(got_param));
        check_value(test, "d_corrupt", 32'd0, 32'(got_corrupt));
        if (exp_opcode == ACCESS_ACK_DATA || exp_denied) begin
            check_value(test, "d_data", exp_data, got_data);
        end
    endtask

    // ==========================================================
    // Bus driving
    // ==========================================================
    // Entered just after a posedge and left at the negedge after the handshake
    task automatic drive_a(input string test, input tl_a_opcode_e op, input tl_addr_t addr,
                           input tl_mask_t mask, input tl_data_t data,
                           input tl_source_t src, input tl_size_t size);
        a_valid   = 1'b1;
        a_opcode  = op;
        a_param   = '0;
        a_size    = size;
        a_source  = src;
        a_address = addr;
        a_mask    = mask;
        a_data    = data;
        @(negedge clk);
        while (!a_ready) @(negedge clk);
        check_value(test, "d_valid before handshake", 32'd0, 32'(d_valid));
        @(posedge clk);  // Handshake edge
        #DRIVE_DELAY;
        a_valid = 1'b0;
        @(negedge clk);
        check_value(test, "d_valid one cycle after handshake", 32'd1, 32'(d_valid));
    endtask

    task automatic capture_d();
        got_opcode  = d_opcode;
        got_param   = d_param;
        got_size    = d_size;
        got_source  = d_source;
        got_data    = d_data;
        got_denied  = d_denied;
        got_corrupt = d_corrupt;
    endtask

    // One complete request with d_ready high
    task automatic send(input string test, input tl_a_opcode_e op, input tl_addr_t addr,
                        input tl_mask_t mask, input tl_data_t data,
                        input tl_source_t src, input tl_size_t size);
        drive_a(test, op, addr, mask, data, src, size);
        capture_d();
        @(posedge clk);  // D beat taken here
        #DRIVE_DELAY;
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic test_reset_state();
        @(negedge clk);
        check_value("reset_state", "d_valid", 32'd0, 32'(d_valid));
        check_value("reset_state", "a_ready", 32'd1, 32'(a_ready));
        check_value("reset_state", "led", 32'h3F, 32'(led));
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic test_full_write_read();
        tl_addr_t addrs [5];
        tl_data_t wdata;
        tl_source_t src;
        addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0150, 32'h0000_0FFC, 32'h0000_2A08};
        foreach (addrs[i]) begin
            wdata = $urandom();
            src   = tl_source_t'(8'h10 + i);
            send("full_write", PUT_FULL_DATA, addrs[i], 4'hF, wdata, src, 3'd2);
            check_response("full_write", ACCESS_ACK, src, 3'd2, 1'b0, '0);
            mem_model[word_index(addrs[i])] = wdata;
        end
        foreach (addrs[i]) begin
            src = tl_source_t'(8'h40 + i);
            send("full_read", GET, addrs[i], 4'hF, '0, src, 3'd2);
            check_response("full_read", ACCESS_ACK_DATA, src, 3'd2, 1'b0,
                           mem_model[word_index(addrs[i])]);
        end
    endtask

    task automatic test_partial_write();
        tl_addr_t addr;
        tl_data_t wdata;
        addr  = 32'h0000_0238;
        wdata = $urandom();
        send("partial_write", PUT_FULL_DATA, addr, 4'hF, wdata, 8'h21, 3'd2);
        check_response("partial_write", ACCESS_ACK, 8'h21, 3'd2, 1'b0, '0);
        mem_model[word_index(addr)] = wdata;
        wdata = $urandom();
        send("partial_write", PUT_PARTIAL_DATA, addr, 4'b0101, wdata, 8'h22, 3'd2);
        check_response("partial_write", ACCESS_ACK, 8'h22, 3'd2, 1'b0, '0);
        mem_model[word_index(addr)] = merge_bytes(mem_model[word_index(addr)], wdata, 4'b0101);
        send("partial_read", GET, addr, 4'hF, '0, 8'h23, 3'd2);
        check_response("partial_read", ACCESS_ACK_DATA, 8'h23, 3'd2, 1'b0,
                       mem_model[word_index(addr)]);
    endtask

    task automatic test_led_output();
        tl_data_t             value;
        logic [LED_COUNT-1:0] exp_led;
        repeat (2) begin
            value   = $urandom();
            exp_led = ~value[LED_COUNT-1:0];  // Active-low pins
            send("led_write", PUT_FULL_DATA, OUT_BASE, 4'hF, value, 8'h31, 3'd2);
            check_response("led_write", ACCESS_ACK, 8'h31, 3'd2, 1'b0, '0);
            check_value("led_write", "led", 32'(exp_led), 32'(led));
            send("led_read", GET, OUT_BASE, 4'hF, '0, 8'h32, 3'd2);
            check_response("led_read", ACCESS_ACK_DATA, 8'h32, 3'd2, 1'b0,
                           tl_data_t'(value[LED_COUNT-1:0]));
        end
    endtask

    task automatic test_unmapped();
        send("unmapped_get", GET, UNMAPPED_ADDR, 4'hF, '0, 8'h5A, 3'd2);
        check_response("unmapped_get", ACCESS_ACK_DATA, 8'h5A, 3'd2, 1'b1, '0);
        send("unmapped_put", PUT_FULL_DATA, UNMAPPED_ADDR, 4'hF, $urandom(), 8'hA5, 3'd2);
        check_response("unmapped_put", ACCESS_ACK, 8'hA5, 3'd2, 1'b1, '0);
    endtask

    task automatic test_backpressure();
        tl_addr_t addr;
        tl_data_t wdata;
        addr  = 32'h0000_0340;
        wdata = $urandom();
        send("backpressure", PUT_FULL_DATA, addr, 4'hF, wdata, 8'h61, 3'd2);
        mem_model[word_index(addr)] = wdata;
        d_ready = 1'b0;
        drive_a("backpressure", GET, addr, 4'hF, '0, 8'h62, 3'd2);
        capture_d();
        check_response("backpressure", ACCESS_ACK_DATA, 8'h62, 3'd2, 1'b0,
                       mem_model[word_index(addr)]);
        repeat (5) begin
            @(negedge clk);
            check_value("backpressure", "d_valid", 32'd1, 32'(d_valid));
            check_value("backpressure", "d_data", got_data, d_data);
            check_value("backpressure", "a_ready", 32'd0, 32'(a_ready));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        d_ready = 1'b1;
        @(negedge clk);
        check_value("backpressure", "d_valid", 32'd1, 32'(d_valid));
        @(posedge clk);  // Beat completes
        #DRIVE_DELAY;
        @(negedge clk);
        check_value("backpressure", "d_valid after beat", 32'd0, 32'(d_valid));
        check_value("backpressure", "a_ready after beat", 32'd1, 32'(a_ready));
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        a_valid   = 1'b0;
        a_opcode  = GET;
        a_param   = '0;
        a_size    = '0;
        a_source  = '0;
        a_address = '0;
        a_mask    = '0;
        a_data    = '0;
        d_ready   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset_state();
        test_full_write_read();
        test_partial_write();
        test_led_output();
        test_unmapped();
        test_backpressure();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/tl_pkg.sv
rtl/soc_map_pkg.sv
rtl/tl_ul_if.sv
rtl/tl_switch.sv
rtl/tl_memory.sv
rtl/tl_ul_output.sv
rtl/soc_top.sv
testbench/tb_soc.sv

// File: Makefile
TOP = tb_soc

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
